/* hw/cycle_timer.sv */
// Saturating cycle counter, shared by start debounce and frame watchdog.
`timescale 1ns/1ps
`default_nettype none

module cycle_timer (
    input  wire                  i_clk,
    input  wire                  i_srstn,
    input  wire                  i_clear,
    input  wire                  i_run,
    output fft_test_pkg::timer_t o_value
);

    always_ff @(posedge i_clk or negedge i_srstn) begin
        if (!i_srstn) begin
            o_value <= '0;
        end else if (i_clear) begin
            o_value <= '0;
        end else if (i_run && (o_value != '1)) begin
            o_value <= o_value + 1'b1; // holds at all ones.
        end
    end

endmodule

`default_nettype wire

/* hw/fft4_burst_core.sv */
// 4-point radix-2 burst FFT, unscaled, natural order, one frame in flight.
// Bin 0 leaves 3 cycles after the last input beat; input stalls until bin 3 is out.
`timescale 1ns/1ps
`default_nettype none

module fft4_burst_core (
    input  wire                    i_clk,
    input  wire                    i_srstn,
    input  wire                    i_xn_valid,
    input  wire fft_test_pkg::xn_beat_t i_xn,
    output logic                   o_xn_ready,
    output logic                   o_xk_valid,
    output fft_test_pkg::xk_beat_t o_xk
);

    fft_test_pkg::sample_t  x_re  [fft_test_pkg::FFT_LEN];
    fft_test_pkg::sample_t  x_im  [fft_test_pkg::FFT_LEN];
    fft_test_pkg::bin_t     s1_re [fft_test_pkg::FFT_LEN]; // a+c, a-c, b+d, b-d.
    fft_test_pkg::bin_t     s1_im [fft_test_pkg::FFT_LEN];
    fft_test_pkg::bin_t     s2_re [fft_test_pkg::FFT_LEN]; // bins in natural order.
    fft_test_pkg::bin_t     s2_im [fft_test_pkg::FFT_LEN];
    fft_test_pkg::bin_idx_t in_cnt;
    fft_test_pkg::bin_idx_t out_idx;
    logic                   busy;
    logic                   s1_go;
    logic                   s2_go;
    logic                   xn_fire;
    logic                   frame_in;
    logic                   out_end;

    assign o_xn_ready = !busy;
    assign xn_fire    = i_xn_valid && o_xn_ready;
    assign frame_in   = xn_fire && (in_cnt == fft_test_pkg::bin_idx_t'(fft_test_pkg::FFT_LEN - 1));
    assign out_end    = o_xk_valid &&
                        (out_idx == fft_test_pkg::bin_idx_t'(fft_test_pkg::FFT_LEN - 1));

    always_ff @(posedge i_clk) begin
        if (xn_fire) begin
            x_re[in_cnt] <= i_xn.re;
            x_im[in_cnt] <= i_xn.im;
        end
    end

    // stage 1 works on the even half a,c and the odd half b,d.
    always_ff @(posedge i_clk) begin
        if (s1_go) begin
            s1_re[0] <= fft_test_pkg::bin_t'(x_re[0]) + fft_test_pkg::bin_t'(x_re[2]);
            s1_im[0] <= fft_test_pkg::bin_t'(x_im[0]) + fft_test_pkg::bin_t'(x_im[2]);
            s1_re[1] <= fft_test_pkg::bin_t'(x_re[0]) - fft_test_pkg::bin_t'(x_re[2]);
            s1_im[1] <= fft_test_pkg::bin_t'(x_im[0]) - fft_test_pkg::bin_t'(x_im[2]);
            s1_re[2] <= fft_test_pkg::bin_t'(x_re[1]) + fft_test_pkg::bin_t'(x_re[3]);
            s1_im[2] <= fft_test_pkg::bin_t'(x_im[1]) + fft_test_pkg::bin_t'(x_im[3]);
            s1_re[3] <= fft_test_pkg::bin_t'(x_re[1]) - fft_test_pkg::bin_t'(x_re[3]);
            s1_im[3] <= fft_test_pkg::bin_t'(x_im[1]) - fft_test_pkg::bin_t'(x_im[3]);
        end
    end

    // stage 2, -j*(b-d) is a swap of re and im with a sign flip.
    always_ff @(posedge i_clk) begin
        if (s2_go) begin
            s2_re[0] <= s1_re[0] + s1_re[2];
            s2_im[0] <= s1_im[0] + s1_im[2];
            s2_re[1] <= s1_re[1] + s1_im[3];
            s2_im[1] <= s1_im[1] - s1_re[3];
            s2_re[2] <= s1_re[0] - s1_re[2];
            s2_im[2] <= s1_im[0] - s1_im[2];
            s2_re[3] <= s1_re[1] - s1_im[3];
            s2_im[3] <= s1_im[1] + s1_re[3];
        end
    end

    always_ff @(posedge i_clk or negedge i_srstn) begin
        if (!i_srstn) begin
            in_cnt     <= '0;
            out_idx    <= '0;
            busy       <= 1'b0;
            s1_go      <= 1'b0;
            s2_go      <= 1'b0;
            o_xk_valid <= 1'b0;
        end else begin
            if (xn_fire)
                in_cnt <= in_cnt + 1'b1;
            s1_go <= frame_in;
            s2_go <= s1_go;
            if (frame_in)
                busy <= 1'b1;
            else if (out_end)
                busy <= 1'b0;
            if (s2_go)
                o_xk_valid <= 1'b1;
            else if (out_end)
                o_xk_valid <= 1'b0;
            if (o_xk_valid)
                out_idx <= out_idx + 1'b1; // back to 0 after bin 3.
        end
    end

    always_comb begin
        o_xk.re      = s2_re[out_idx];
        o_xk.im      = s2_im[out_idx];
        o_xk.last    = (out_idx == fft_test_pkg::bin_idx_t'(fft_test_pkg::FFT_LEN - 1));
        o_xk.bin_idx = out_idx;
    end

endmodule

`default_nettype wire

/* hw/fft_onboard_top.sv */
// Self-test harness top. i_srstn is used as is, with no synchronizer.
// o_xk_valid/o_xk mirror the FFT output stream for debug.
`timescale 1ns/1ps
`default_nettype none

module fft_onboard_top (
    input  wire                    i_clk,
    input  wire                    i_srstn,
    input  wire                    i_start_test,
    output wire                    o_err,
    output wire                    o_chk_finished,
    output wire                    o_xk_valid,
    output wire fft_test_pkg::xk_beat_t o_xk
);

    wire                         frame_req;
    wire                         frame_ack;
    wire                         chk_clear;
    wire                         frame_done;
    wire                         mismatch;
    wire                         timer_clear;
    wire                         timer_run;
    wire fft_test_pkg::timer_t   timer_value;
    wire                         xn_valid;
    wire                         xn_ready;
    wire fft_test_pkg::xn_beat_t xn;

    test_ctrl_fsm u_ctrl (
        .i_clk          (i_clk),
        .i_srstn        (i_srstn),
        .i_start_test   (i_start_test),
        .o_frame_req    (frame_req),
        .i_frame_ack    (frame_ack),
        .o_chk_clear    (chk_clear),
        .i_frame_done   (frame_done),
        .i_mismatch     (mismatch),
        .o_timer_clear  (timer_clear),
        .o_timer_run    (timer_run),
        .i_timer_value  (timer_value),
        .o_err          (o_err),
        .o_chk_finished (o_chk_finished)
    );

    cycle_timer u_timer (
        .i_clk   (i_clk),
        .i_srstn (i_srstn),
        .i_clear (timer_clear),
        .i_run   (timer_run),
        .o_value (timer_value)
    );

    frame_gen u_gen (
        .i_clk       (i_clk),
        .i_srstn     (i_srstn),
        .i_frame_req (frame_req),
        .o_frame_ack (frame_ack),
        .o_xn_valid  (xn_valid),
        .o_xn        (xn),
        .i_xn_ready  (xn_ready)
    );

    fft4_burst_core u_fft (
        .i_clk      (i_clk),
        .i_srstn    (i_srstn),
        .i_xn_valid (xn_valid),
        .i_xn       (xn),
        .o_xn_ready (xn_ready),
        .o_xk_valid (o_xk_valid),
        .o_xk       (o_xk)
    );

    frame_chk u_chk (
        .i_clk        (i_clk),
        .i_srstn      (i_srstn),
        .i_clear      (chk_clear),
        .i_xk_valid   (o_xk_valid),
        .i_xk         (o_xk),
        .o_frame_done (frame_done),
        .o_mismatch   (mismatch)
    );

endmodule

`default_nettype wire

/* hw/fft_test_pkg.sv */
// Shared widths, stream beats and the test frame rule for the FFT self-test.
// Only the 4-point unscaled natural-order transform is covered.
`default_nettype none

package fft_test_pkg;

    localparam int LOG2_FFT_LEN    = 2;
    localparam int FFT_LEN         = 4;
    localparam int INPUT_WIDTH     = 8;
    localparam int OUTPUT_WIDTH    = INPUT_WIDTH + LOG2_FFT_LEN + 1;
    localparam int TEST_FRAME_NUM  = 4;
    localparam int DEBOUNCE_CYCLES = 16;
    localparam int MAX_FFT_CYCLES  = 16;
    localparam int TIMER_WIDTH     = 5;

    typedef logic signed [INPUT_WIDTH-1:0]     sample_t;
    typedef logic signed [OUTPUT_WIDTH-1:0]    bin_t;
    typedef logic [LOG2_FFT_LEN-1:0]           bin_idx_t;
    typedef logic [$clog2(TEST_FRAME_NUM)-1:0] frame_idx_t;
    typedef logic [TIMER_WIDTH-1:0]            timer_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
        logic    last;
    } xn_beat_t;

    typedef struct packed {
        bin_t     re;
        bin_t     im;
        logic     last;
        bin_idx_t bin_idx;
    } xk_beat_t;

    typedef enum logic [2:0] {
        IDLE,
        DEBOUNCE,
        REQ_FRAME,
        WAIT_ACK,
        WAIT_CHK,
        DONE
    } ctrl_state_t;

    // sample k of frame f, components wrap modulo 256.
    function automatic xn_beat_t frame_sample(input frame_idx_t f, input bin_idx_t k);
        xn_beat_t s;
        s.re   = sample_t'(f * 8'd37 + k * 8'd19);
        s.im   = sample_t'(f * 8'd11 - k * 8'd23);
        s.last = (k == bin_idx_t'(FFT_LEN - 1));
        return s;
    endfunction

endpackage

`default_nettype wire

/* hw/frame_chk.sv */
// Checks each bin against a direct DFT sum of the generated frame.
// Frame numbering follows the generator, so it is only cleared by reset.
`timescale 1ns/1ps
`default_nettype none

module frame_chk (
    input  wire                    i_clk,
    input  wire                    i_srstn,
    input  wire                    i_clear,
    input  wire                    i_xk_valid,
    input  wire fft_test_pkg::xk_beat_t i_xk,
    output logic                   o_frame_done,
    output logic                   o_mismatch
);

    fft_test_pkg::frame_idx_t frame_num;
    fft_test_pkg::bin_idx_t   exp_idx;
    fft_test_pkg::bin_idx_t   rot;
    fft_test_pkg::xn_beat_t   xs;
    fft_test_pkg::bin_t       ref_re;
    fft_test_pkg::bin_t       ref_im;
    logic                     exp_last;
    logic                     bad_bin;

    // X[k] = sum of x[n] * (-j)^(n*k), exponent taken modulo 4.
    always_comb begin
        ref_re = '0;
        ref_im = '0;
        xs     = '0;
        rot    = '0;
        for (int n = 0; n < fft_test_pkg::FFT_LEN; n++) begin
            xs  = fft_test_pkg::frame_sample(frame_num, fft_test_pkg::bin_idx_t'(n));
            rot = fft_test_pkg::bin_idx_t'(n) * exp_idx;
            case (rot)
                2'd0: begin
                    ref_re = ref_re + xs.re;
                    ref_im = ref_im + xs.im;
                end
                2'd1: begin
                    ref_re = ref_re + xs.im;
                    ref_im = ref_im - xs.re;
                end
                2'd2: begin
                    ref_re = ref_re - xs.re;
                    ref_im = ref_im - xs.im;
                end
                default: begin
                    ref_re = ref_re - xs.im;
                    ref_im = ref_im + xs.re;
                end
            endcase
        end
    end

    assign exp_last = (exp_idx == fft_test_pkg::bin_idx_t'(fft_test_pkg::FFT_LEN - 1));
    assign bad_bin  = (i_xk.re != ref_re) || (i_xk.im != ref_im) ||
                      (i_xk.bin_idx != exp_idx) || (i_xk.last != exp_last);

    always_ff @(posedge i_clk or negedge i_srstn) begin
        if (!i_srstn) begin
            frame_num    <= '0;
            exp_idx      <= '0;
            o_frame_done <= 1'b0;
            o_mismatch   <= 1'b0;
        end else begin
            o_frame_done <= i_xk_valid && exp_last;
            o_mismatch   <= i_xk_valid && bad_bin;
            if (i_clear) begin
                exp_idx <= '0; // realign after an aborted frame.
            end else if (i_xk_valid) begin
                exp_idx <= exp_idx + 1'b1;
                if (exp_last)
                    frame_num <= frame_num + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/frame_gen.sv */
// Test frame source. Frame number runs on modulo 4 across runs and is never
// cleared except by reset.
`timescale 1ns/1ps
`default_nettype none

module frame_gen (
    input  wire                    i_clk,
    input  wire                    i_srstn,
    input  wire                    i_frame_req,
    output logic                   o_frame_ack,
    output logic                   o_xn_valid,
    output fft_test_pkg::xn_beat_t o_xn,
    input  wire                    i_xn_ready
);

    fft_test_pkg::frame_idx_t frame_num;
    fft_test_pkg::bin_idx_t   sample_idx;
    logic                     busy;
    logic                     xn_fire;

    assign xn_fire    = busy && i_xn_ready;
    assign o_xn_valid = busy;
    assign o_xn       = fft_test_pkg::frame_sample(frame_num, sample_idx); // steady while stalled.

    always_ff @(posedge i_clk or negedge i_srstn) begin
        if (!i_srstn) begin
            busy        <= 1'b0;
            o_frame_ack <= 1'b0;
            frame_num   <= '0;
            sample_idx  <= '0;
        end else begin
            if (i_frame_req && !busy && !o_frame_ack) begin
                busy <= 1'b1;
            end else if (xn_fire) begin
                sample_idx <= sample_idx + 1'b1; // wraps to 0 after last beat.
                if (o_xn.last) begin
                    busy        <= 1'b0;
                    o_frame_ack <= 1'b1;
                    frame_num   <= frame_num + 1'b1;
                end
            end
            if (o_frame_ack && !i_frame_req)
                o_frame_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/test_ctrl_fsm.sv */
// Run sequencer: debounced start, four-phase frame requests, latency watchdog.
// o_err is sticky until the next run starts. A press during a run is ignored.
`timescale 1ns/1ps
`default_nettype none

module test_ctrl_fsm (
    input  wire                  i_clk,
    input  wire                  i_srstn,
    input  wire                  i_start_test,
    output logic                 o_frame_req,
    input  wire                  i_frame_ack,
    output logic                 o_chk_clear,
    input  wire                  i_frame_done,
    input  wire                  i_mismatch,
    output logic                 o_timer_clear,
    output logic                 o_timer_run,
    input  wire fft_test_pkg::timer_t i_timer_value,
    output logic                 o_err,
    output logic                 o_chk_finished
);

    fft_test_pkg::ctrl_state_t state;
    fft_test_pkg::ctrl_state_t state_nxt;
    fft_test_pkg::frame_idx_t  frame_cnt;
    logic                      start_prev;
    logic                      err_lck;
    logic                      start_run;
    logic                      wd_expired;
    logic                      last_frame;

    // rise cycle and DEBOUNCE entry cycle are already counted as high.
    assign start_run  = (state == fft_test_pkg::DEBOUNCE) && i_start_test &&
                        (i_timer_value ==
                         fft_test_pkg::timer_t'(fft_test_pkg::DEBOUNCE_CYCLES - 2));
    assign wd_expired = (state == fft_test_pkg::WAIT_CHK) &&
                        (i_timer_value >= fft_test_pkg::timer_t'(fft_test_pkg::MAX_FFT_CYCLES));
    assign last_frame = (frame_cnt == fft_test_pkg::frame_idx_t'(fft_test_pkg::TEST_FRAME_NUM - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            fft_test_pkg::IDLE: begin
                if (i_start_test && !start_prev)
                    state_nxt = fft_test_pkg::DEBOUNCE;
            end
            fft_test_pkg::DEBOUNCE: begin
                if (!i_start_test)
                    state_nxt = fft_test_pkg::IDLE; // glitch, back to waiting.
                else if (start_run)
                    state_nxt = fft_test_pkg::REQ_FRAME;
            end
            fft_test_pkg::REQ_FRAME: begin
                if (!i_frame_ack)
                    state_nxt = fft_test_pkg::WAIT_ACK;
            end
            fft_test_pkg::WAIT_ACK: begin
                if (i_frame_ack)
                    state_nxt = fft_test_pkg::WAIT_CHK;
            end
            fft_test_pkg::WAIT_CHK: begin
                if (wd_expired || (i_frame_done && last_frame))
                    state_nxt = fft_test_pkg::DONE;
                else if (i_frame_done)
                    state_nxt = fft_test_pkg::REQ_FRAME;
            end
            default: state_nxt = fft_test_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_srstn) begin
        if (!i_srstn) begin
            state      <= fft_test_pkg::IDLE;
            start_prev <= 1'b1; // start held through reset is no press.
            frame_cnt  <= '0;
            err_lck    <= 1'b0;
        end else begin
            state      <= state_nxt;
            start_prev <= i_start_test;
            if (start_run)
                frame_cnt <= '0;
            else if ((state == fft_test_pkg::WAIT_CHK) && i_frame_done)
                frame_cnt <= frame_cnt + 1'b1;
            if (start_run)
                err_lck <= 1'b0;
            else if (i_mismatch || wd_expired)
                err_lck <= 1'b1;
        end
    end

    assign o_frame_req    = (state == fft_test_pkg::WAIT_ACK);
    assign o_chk_clear    = start_run;
    assign o_timer_clear  = (state == fft_test_pkg::IDLE) || (state == fft_test_pkg::REQ_FRAME);
    assign o_timer_run    = ((state == fft_test_pkg::DEBOUNCE) && i_start_test) ||
                            (state == fft_test_pkg::WAIT_ACK) || (state == fft_test_pkg::WAIT_CHK);
    assign o_err          = err_lck;
    assign o_chk_finished = (state == fft_test_pkg::IDLE) || (state == fft_test_pkg::DEBOUNCE) ||
                            (state == fft_test_pkg::DONE);

endmodule

`default_nettype wire

/* src.f */
hw/fft_test_pkg.sv
hw/cycle_timer.sv
hw/test_ctrl_fsm.sv
hw/frame_gen.sv
hw/fft4_burst_core.sv
hw/frame_chk.sv
hw/fft_onboard_top.sv
testbench/tb_fft_onboard.sv

/* testbench/tb_fft_onboard.sv */
// Self-test harness testbench. Expected bins come from an integer DFT of the frame rule.
// Tap frame numbers are tracked from reset, so they carry on across runs.
`timescale 1ns/1ps
`default_nettype none

module tb_fft_onboard;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 5;
    localparam int GAP_MAX     = 20;
    localparam int TEST_COUNT  = 5;
    localparam int RUN_CYCLES  = fft_test_pkg::TEST_FRAME_NUM * 2 * fft_test_pkg::MAX_FFT_CYCLES;
    localparam int TEST_CYCLES = GAP_MAX + 4 * fft_test_pkg::DEBOUNCE_CYCLES + RUN_CYCLES + 60;
    localparam int CYCLE_LIMIT = 2 * TEST_COUNT * TEST_CYCLES;
    localparam int RUN_BINS    = fft_test_pkg::TEST_FRAME_NUM * fft_test_pkg::FFT_LEN;

    logic                   i_clk;
    logic                   i_srstn;
    logic                   i_start_test;
    wire                    o_err;
    wire                    o_chk_finished;
    wire                    o_xk_valid;
    fft_test_pkg::xk_beat_t o_xk;

    string test_name   = "reset_state";
    string waiting_for = "reset release";
    int    err_cnt     = 0;
    int    test_err0   = 0;
    int    tests_pass  = 0;
    int    tests_fail  = 0;
    int    bin_total   = 0;
    int    tap_frame   = 0;
    int    tap_bin     = 0;
    int    cycle_cnt   = 0;
    int    exp_re;
    int    exp_im;
    int    bins_before;
    bit    idle_expected = 1'b0;

    fft_onboard_top dut (
        .i_clk          (i_clk),
        .i_srstn        (i_srstn),
        .i_start_test   (i_start_test),
        .o_err          (o_err),
        .o_chk_finished (o_chk_finished),
        .o_xk_valid     (o_xk_valid),
        .o_xk           (o_xk)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic int wrap8(input int v);
        int m;
        m = v & 255;
        if (m > 127)
            m = m - 256;
        return m;
    endfunction

    // X[k] = sum x[n] * (cos - j sin)(2*pi*n*k/4) with exact twiddles.
    function automatic int dft_part(input int f, input int k, input bit want_im);
        int acc_re;
        int acc_im;
        int xr;
        int xi;
        int wr;
        int wi;
        int m;
        acc_re = 0;
        acc_im = 0;
        for (int n = 0; n < fft_test_pkg::FFT_LEN; n++) begin
            xr = wrap8(f * 37 + n * 19);
            xi = wrap8(f * 11 - n * 23);
            m  = (n * k) % 4;
            wr = (m == 0) ? 1 : ((m == 2) ? -1 : 0);
            wi = (m == 1) ? -1 : ((m == 3) ? 1 : 0);
            acc_re = acc_re + xr * wr - xi * wi;
            acc_im = acc_im + xr * wi + xi * wr;
        end
        return want_im ? acc_im : acc_re;
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        err_cnt++;
        $display("ERROR %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge i_clk);
        #DRIVE_DELAY;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == test_err0) begin
            tests_pass++;
            $display("test %-22s ok", test_name);
        end else begin
            tests_fail++;
            $display("test %-22s failed with %0d errors", test_name, err_cnt - test_err0);
        end
    endtask

    task automatic wait_finished(input logic level, input string what);
        waiting_for = what;
        while (o_chk_finished !== level)
            tick(1);
    endtask

    // each tap beat against the reference in index order with last on bin 3.
    always @(negedge i_clk) begin
        if (i_srstn && o_xk_valid) begin
            exp_re = dft_part(tap_frame % 4, tap_bin, 1'b0);
            exp_im = dft_part(tap_frame % 4, tap_bin, 1'b1);
            assert (int'(o_xk.bin_idx) == tap_bin)
                else report_mismatch("bin index", tap_bin, int'(o_xk.bin_idx));
            assert (o_xk.last == (tap_bin == fft_test_pkg::FFT_LEN - 1))
                else report_mismatch("last flag", tap_bin == fft_test_pkg::FFT_LEN - 1, o_xk.last);
            assert ($signed(o_xk.re) == exp_re)
                else report_mismatch("real part", exp_re, $signed(o_xk.re));
            assert ($signed(o_xk.im) == exp_im)
                else report_mismatch("imag part", exp_im, $signed(o_xk.im));
            bin_total++;
            if (tap_bin == fft_test_pkg::FFT_LEN - 1) begin
                tap_bin = 0;
                tap_frame++;
            end else begin
                tap_bin++;
            end
        end
        if (i_srstn) begin
            assert (!o_err) else report_mismatch("o_err", 0, o_err);
        end
        if (i_srstn && idle_expected) begin
            assert (o_chk_finished) else report_mismatch("o_chk_finished", 1, o_chk_finished);
            assert (!o_xk_valid) else report_mismatch("o_xk_valid", 0, o_xk_valid);
        end
    end

    task automatic short_glitch();
        tick(2 + $urandom % GAP_MAX);
        bins_before   = bin_total;
        idle_expected = 1'b1;
        i_start_test  = 1'b1;
        tick(1 + $urandom % (fft_test_pkg::DEBOUNCE_CYCLES - 1)); // always short of a press.
        i_start_test  = 1'b0;
        tick(fft_test_pkg::DEBOUNCE_CYCLES + 8);
        idle_expected = 1'b0;
        assert (bin_total == bins_before)
            else report_mismatch("tap beats", bins_before, bin_total);
    endtask

    task automatic full_run(input bit extra_press);
        tick(2 + $urandom % GAP_MAX);
        bins_before  = bin_total;
        i_start_test = 1'b1;
        wait_finished(1'b0, "o_chk_finished to fall after a held press");
        if (extra_press) begin
            tick(2);
            i_start_test = 1'b0;
            tick(3);
            i_start_test = 1'b1; // fresh edge while frames are in flight.
            tick(fft_test_pkg::DEBOUNCE_CYCLES + 4);
        end
        wait_finished(1'b1, "o_chk_finished to rise at the end of the run");
        i_start_test  = 1'b0;
        idle_expected = 1'b1;
        tick(fft_test_pkg::DEBOUNCE_CYCLES);
        idle_expected = 1'b0;
        assert (bin_total - bins_before == RUN_BINS)
            else report_mismatch("bins in run", RUN_BINS, bin_total - bins_before);
    endtask

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles while waiting for %s", cycle_cnt, waiting_for);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(98731));
        i_srstn      = 1'b0;
        i_start_test = 1'b0;
        tick(4);
        i_srstn = 1'b1;
        tick(2);
        waiting_for = "the test sequence";

        begin_test("reset_state");
        assert (o_chk_finished === 1'b1) else report_mismatch("o_chk_finished", 1, o_chk_finished);
        assert (o_err === 1'b0) else report_mismatch("o_err", 0, o_err);
        assert (o_xk_valid === 1'b0) else report_mismatch("o_xk_valid", 0, o_xk_valid);
        end_test();

        begin_test("short_glitch");
        short_glitch();
        end_test();

        begin_test("run_with_extra_press");
        full_run(1'b1);
        end_test();

        begin_test("glitch_after_run");
        short_glitch();
        end_test();

        begin_test("second_run");
        full_run(1'b0);
        end_test();

        $display("tests %0d, passed %0d, failed %0d, errors %0d, bins seen %0d",
                 tests_pass + tests_fail, tests_pass, tests_fail, err_cnt, bin_total);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
